// File: verilog.f
+incdir+tests
design/hisPixelPkg.sv
design/hisRegPkg.sv
design/sampleCombiner.sv
design/binClassifier.sv
design/binCounterBank.sv
design/apbRegFile.sv
design/hisBuilderTop.sv
tests/hisBuilderTB.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module hisBuilderTB -o hisBuilderSim

output=$(./obj_dir/hisBuilderSim)
echo "$output"
echo "$output" | grep -q "All tests passed"

// File: tests/hisBuilderTests.svh
`ifndef HIS_BUILDER_TESTS_SVH
`define HIS_BUILDER_TESTS_SVH

localparam int KindFixed  = 0; // fixedSamples, every frame
localparam int KindEdge   = 1; // pixels around the window edges
localparam int KindRandom = 2;
localparam int KindNarrow = 3; // random samples that all fall in bin 1

localparam int NumTests       = 7;
localparam int PixelsPerFrame = hisPixelPkg::PixelsPerRow * hisPixelPkg::RowsPerFrame;
localparam int SamplesPerFrame = PixelsPerFrame * hisPixelPkg::SamplesPerPixel;

// columns: name, winLow, binShift, frames, sample kind, wrEn gap cycles,
// enable dropped mid-pair before the frames
// expected bin counts come from the pair average and the bin rule per pixel
string testName [NumTests] = '{
    "pairAverage", "windowEdgeShift2", "windowEdgeShift5", "frameCount",
    "frameCountGaps", "enableRestart", "saturation"
};
int testWinLow [NumTests] = '{100, 200, 200, 0, 300, 50, 100};
int testShift  [NumTests] = '{5, 2, 5, 7, 4, 6, 3};
int testFrames [NumTests] = '{1, 2, 1, 5, 3, 2, 10925}; // last one overflows 16 bits
int testKind   [NumTests] = '{
    KindFixed, KindEdge, KindEdge, KindRandom, KindRandom, KindRandom, KindNarrow
};
int testGap    [NumTests] = '{0, 0, 1, 0, 3, 0, 0};
int testEnToggle [NumTests] = '{0, 0, 0, 0, 0, 1, 0};

// sample pairs of one frame, pixel 0 first
int fixedSamples [SamplesPerFrame] = '{
    108, 511,
    0, 0,
    1023, 1023,
    99, 101,
    100, 101,
    400, 401
};

`endif

// File: tests/hisBuilderTB.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderTB;

    `include "hisBuilderTests.svh"

    localparam int RowOverhead = 400; // APB setup and readback cycles per row
    localparam int MaxCount    = (1 << hisPixelPkg::CountWidth) - 1;

    logic                            clk;
    logic                            reset;
    logic                            wrEn;
    logic [hisPixelPkg::Np-1:0]      data;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [hisRegPkg::AddrWidth-1:0] paddr;
    logic [hisRegPkg::DataWidth-1:0] pwdata;
    logic [hisRegPkg::DataWidth-1:0] prdata;
    logic                            pready;

    int expBins [hisPixelPkg::BinTotal];
    int rowErrors;
    int passCount;
    int failCount;
    string curTest;

    hisBuilderTop dut0 (
        .clk(clk), .reset(reset), .wrEn(wrEn), .data(data),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    always #2 clk = ~clk;

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] value);
        @(posedge clk);
        psel    <= 1'b1; // setup
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= value;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic checkValue(input string name, input string what,
                              input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Error %s %s: expected %0d, actual %0d", name, what, expected, actual);
            rowErrors++;
        end
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] value);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        #1 value = prdata; // mid access phase
        checkValue(curTest, "pready", 1, int'(pready));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic sendSample(input int sample, input int gap);
        @(posedge clk);
        wrEn <= 1'b1;
        data <= sample[hisPixelPkg::Np-1:0];
        repeat (gap) begin
            @(posedge clk);
            wrEn <= 1'b0;
        end
    endtask

    task automatic stopStream();
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    function automatic int binOf(input int pixel, input int winLow, input int shift);
        int d;
        if (pixel < winLow)
            return 0;
        d = (pixel - winLow) >> shift;
        if (d < hisPixelPkg::BinCount)
            return d + 1;
        return hisPixelPkg::BinTotal - 1;
    endfunction

    task automatic makePair(input int r, input int p, output int a, output int b);
        int top;
        top = testWinLow[r] + (hisPixelPkg::BinCount << testShift[r]); // first overflow value
        case (testKind[r])
            KindFixed: begin
                a = fixedSamples[2 * p];
                b = fixedSamples[2 * p + 1];
            end
            KindEdge: begin
                case (p)
                    0: a = testWinLow[r] - 1;
                    1: a = testWinLow[r];
                    2: a = top - 1;
                    3: a = top;
                    4: a = 1023;
                    default: a = 0;
                endcase
                b = a;
            end
            KindNarrow: begin
                a = testWinLow[r] + int'($urandom % (1 << testShift[r]));
                b = testWinLow[r] + int'($urandom % (1 << testShift[r]));
            end
            default: begin
                a = int'($urandom % 1024);
                b = int'($urandom % 1024);
            end
        endcase
    endtask

    task automatic readBins(input string name, input string what, input int cleared);
        logic [31:0] value;
        for (int i = 0; i < hisPixelPkg::BinTotal; i++) begin
            apbRead(8'(hisRegPkg::AddrBinBase + 4 * i), value);
            checkValue(name, $sformatf("%s %0d", what, i), cleared ? 0 : expBins[i],
                       int'(value));
        end
    endtask

    task automatic runRow(input int r);
        int a;
        int b;
        int bin;
        int tries;
        logic [31:0] value;
        rowErrors = 0;
        curTest   = testName[r];
        for (int i = 0; i < hisPixelPkg::BinTotal; i++)
            expBins[i] = 0;
        apbWrite(hisRegPkg::AddrCtrl, 32'(1) << hisRegPkg::CtrlClearBit); // stop and clear
        apbRead(hisRegPkg::AddrCtrl, value);
        checkValue(testName[r], "ctrl after clear", 0, int'(value));
        apbWrite(hisRegPkg::AddrWinLow, 32'(testWinLow[r]));
        apbWrite(hisRegPkg::AddrShift, 32'(testShift[r]));
        readBins(testName[r], "cleared bin", 1);
        apbRead(hisRegPkg::AddrFrames, value);
        checkValue(testName[r], "cleared frames", 0, int'(value));
        if (testEnToggle[r] != 0) begin
            apbWrite(hisRegPkg::AddrCtrl, 32'(1) << hisRegPkg::CtrlEnableBit);
            sendSample(77, 0); // half pair, dropped when enable falls
            stopStream();
            apbWrite(hisRegPkg::AddrCtrl, 32'h0);
            repeat (3) sendSample(int'($urandom % 1024), 0);
            stopStream();
        end
        apbWrite(hisRegPkg::AddrCtrl, 32'(1) << hisRegPkg::CtrlEnableBit);
        for (int f = 0; f < testFrames[r]; f++) begin
            for (int p = 0; p < PixelsPerFrame; p++) begin
                makePair(r, p, a, b);
                bin = binOf((a + b) >> 1, testWinLow[r], testShift[r]);
                if (expBins[bin] < MaxCount)
                    expBins[bin]++;
                sendSample(a, testGap[r]);
                sendSample(b, testGap[r]);
            end
        end
        stopStream();
        // last frame done marks the end of the pipeline
        tries = 0;
        apbRead(hisRegPkg::AddrFrames, value);
        while ((int'(value) != testFrames[r]) && (tries < 10)) begin
            apbRead(hisRegPkg::AddrFrames, value);
            tries++;
        end
        checkValue(testName[r], "frames", testFrames[r], int'(value));
        readBins(testName[r], "bin", 0);
        apbRead(hisRegPkg::AddrWinLow, value);
        checkValue(testName[r], "winLow readback", testWinLow[r], int'(value));
        apbRead(hisRegPkg::AddrShift, value);
        checkValue(testName[r], "binShift readback", testShift[r], int'(value));
        apbRead(hisRegPkg::AddrCtrl, value);
        checkValue(testName[r], "ctrl readback", 1 << hisRegPkg::CtrlEnableBit, int'(value));
        if (rowErrors == 0) begin
            passCount++;
            $display("%s: ok", testName[r]);
        end else begin
            failCount++;
            $display("%s: %0d checks wrong", testName[r], rowErrors);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        wrEn      = 1'b0;
        data      = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        passCount = 0;
        failCount = 0;
        curTest   = "reset";
        void'($urandom(20008));
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NumTests; r++)
            runRow(r);
        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        longint cycles;
        cycles = 0;
        for (int r = 0; r < NumTests; r++)
            cycles += RowOverhead + testFrames[r] * SamplesPerFrame * (1 + testGap[r]);
        #(cycles * 4 + 1000);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/hisBuilderTop.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderTop (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wrEn,
    input  logic [hisPixelPkg::Np-1:0]      data,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [hisRegPkg::AddrWidth-1:0] paddr,
    input  logic [hisRegPkg::DataWidth-1:0] pwdata,
    output logic [hisRegPkg::DataWidth-1:0] prdata,
    output logic                            pready
);

    logic                                    enable;
    logic [hisPixelPkg::Np-1:0]              winLow;
    logic [hisRegPkg::ShiftWidth-1:0]        binShift;
    logic                                    clearPulse;
    logic                                    pixelValid;
    logic [hisPixelPkg::Np-1:0]              pixelValue;
    logic                                    frameDone;
    logic                                    binValid;
    logic [hisPixelPkg::BinIdxWidth-1:0]     binIdx;
    logic                                    frameDoneD;
    logic [hisPixelPkg::BinIdxWidth-1:0]     rdBinIdx;
    logic [hisPixelPkg::CountWidth-1:0]      rdCount;
    logic [hisPixelPkg::FrameCountWidth-1:0] frameCount;

    sampleCombiner combinerU0 (
        .clk(clk), .reset(reset), .enable(enable), .wrEn(wrEn), .data(data),
        .pixelValid(pixelValid), .pixelValue(pixelValue), .frameDone(frameDone)
    );

    binClassifier classifierU0 (
        .clk(clk), .reset(reset), .pixelValid(pixelValid), .pixelValue(pixelValue),
        .frameDone(frameDone), .winLow(winLow), .binShift(binShift),
        .binValid(binValid), .binIdx(binIdx), .frameDoneD(frameDoneD)
    );

    binCounterBank counterU0 (
        .clk(clk), .reset(reset), .binValid(binValid), .binIdx(binIdx),
        .frameDoneD(frameDoneD), .clearPulse(clearPulse), .rdBinIdx(rdBinIdx),
        .rdCount(rdCount), .frameCount(frameCount)
    );

    apbRegFile regFileU0 (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .rdCount(rdCount), .frameCount(frameCount),
        .prdata(prdata), .pready(pready), .enable(enable), .winLow(winLow),
        .binShift(binShift), .clearPulse(clearPulse), .rdBinIdx(rdBinIdx)
    );

endmodule

`default_nettype wire

// File: design/apbRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module apbRegFile (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [hisRegPkg::AddrWidth-1:0]         paddr,
    input  logic [hisRegPkg::DataWidth-1:0]         pwdata,
    input  logic [hisPixelPkg::CountWidth-1:0]      rdCount,
    input  logic [hisPixelPkg::FrameCountWidth-1:0] frameCount,
    output logic [hisRegPkg::DataWidth-1:0]         prdata,
    output logic                                    pready,
    output logic                                    enable,
    output logic [hisPixelPkg::Np-1:0]              winLow,
    output logic [hisRegPkg::ShiftWidth-1:0]        binShift,
    output logic                                    clearPulse,
    output logic [hisPixelPkg::BinIdxWidth-1:0]     rdBinIdx
);

    hisRegPkg::apbPhase curPhase;
    hisRegPkg::apbPhase prevPhase;

    logic                           wrAccess;
    logic                           binSel;
    logic [hisRegPkg::AddrWidth-1:0] binOffset;

    assign pready   = 1'b1; // no wait states
    assign wrAccess = psel && penable && pwrite;

    assign binOffset = paddr - hisRegPkg::AddrBinBase;
    assign rdBinIdx  = binOffset[hisPixelPkg::BinIdxWidth+1:2];
    assign binSel    = (paddr >= hisRegPkg::AddrBinBase) && (paddr[1:0] == 2'b00) &&
                       (paddr < hisRegPkg::AddrBinBase + 4 * hisPixelPkg::BinTotal);

    always_ff @(posedge clk) begin
        if (reset) begin
            enable     <= 1'b0;
            winLow     <= '0;
            binShift   <= '0;
            clearPulse <= 1'b0;
        end else begin
            clearPulse <= 1'b0;
            if (wrAccess) begin
                case (paddr)
                    hisRegPkg::AddrCtrl: begin
                        enable     <= pwdata[hisRegPkg::CtrlEnableBit];
                        clearPulse <= pwdata[hisRegPkg::CtrlClearBit]; // one-cycle pulse
                    end
                    hisRegPkg::AddrWinLow: winLow   <= pwdata[hisPixelPkg::Np-1:0];
                    hisRegPkg::AddrShift:  binShift <= pwdata[hisRegPkg::ShiftWidth-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            hisRegPkg::AddrCtrl:   prdata[hisRegPkg::CtrlEnableBit] = enable;
            hisRegPkg::AddrWinLow: prdata[hisPixelPkg::Np-1:0] = winLow;
            hisRegPkg::AddrShift:  prdata[hisRegPkg::ShiftWidth-1:0] = binShift;
            hisRegPkg::AddrFrames: prdata[hisPixelPkg::FrameCountWidth-1:0] = frameCount;
            default: begin
                if (binSel)
                    prdata[hisPixelPkg::CountWidth-1:0] = rdCount;
            end
        endcase
    end

    // bus phase as seen this cycle
    always_comb begin
        if (!psel)
            curPhase = hisRegPkg::idle;
        else if (penable)
            curPhase = hisRegPkg::access;
        else
            curPhase = hisRegPkg::setup;
    end

    always_ff @(posedge clk) begin
        if (reset)
            prevPhase <= hisRegPkg::idle;
        else
            prevPhase <= curPhase;
    end

    accessAfterSetup: assert property (@(posedge clk) disable iff (reset)
        penable |-> (psel && (prevPhase == hisRegPkg::setup)));

endmodule

`default_nettype wire

// File: design/binCounterBank.sv
`timescale 1ns/1ps
`default_nettype none

module binCounterBank (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    binValid,
    input  logic [hisPixelPkg::BinIdxWidth-1:0]     binIdx,
    input  logic                                    frameDoneD,
    input  logic                                    clearPulse,
    input  logic [hisPixelPkg::BinIdxWidth-1:0]     rdBinIdx,
    output logic [hisPixelPkg::CountWidth-1:0]      rdCount,
    output logic [hisPixelPkg::FrameCountWidth-1:0] frameCount
);

    logic [hisPixelPkg::CountWidth-1:0] counts [hisPixelPkg::BinTotal];

    always_ff @(posedge clk) begin
        if (reset || clearPulse) begin
            for (int i = 0; i < hisPixelPkg::BinTotal; i++)
                counts[i] <= '0;
            frameCount <= '0; // clear wins over same-cycle increment
        end else begin
            if (binValid && (counts[binIdx] != '1))
                counts[binIdx] <= counts[binIdx] + 1'b1; // saturate at max
            if (frameDoneD)
                frameCount <= frameCount + 1'b1;
        end
    end

    always_comb begin
        if (rdBinIdx < hisPixelPkg::BinTotal)
            rdCount = counts[rdBinIdx];
        else
            rdCount = '0;
    end

    for (genvar g = 0; g < hisPixelPkg::BinTotal; g++) begin : genSatCheck
        // a full counter stays full until software clears it
        counterHolds: assert property (@(posedge clk) disable iff (reset)
            ((counts[g] == '1) && !clearPulse) |=> (counts[g] == '1));
    end

endmodule

`default_nettype wire

// File: design/binClassifier.sv
`timescale 1ns/1ps
`default_nettype none

module binClassifier (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                pixelValid,
    input  logic [hisPixelPkg::Np-1:0]          pixelValue,
    input  logic                                frameDone,
    input  logic [hisPixelPkg::Np-1:0]          winLow,
    input  logic [hisRegPkg::ShiftWidth-1:0]    binShift,
    output logic                                binValid,
    output logic [hisPixelPkg::BinIdxWidth-1:0] binIdx,
    output logic                                frameDoneD
);

    logic [hisPixelPkg::Np-1:0]          offset;
    logic [hisPixelPkg::Np-1:0]          scaled;
    logic [hisPixelPkg::BinIdxWidth-1:0] binNext;

    assign offset = pixelValue - winLow;
    assign scaled = offset >> binShift;

    always_comb begin
        if (pixelValue < winLow)
            binNext = hisPixelPkg::BinUnderflow;
        else if (scaled < hisPixelPkg::BinCount)
            binNext = scaled[hisPixelPkg::BinIdxWidth-1:0] + 1'b1; // window bins start at 1
        else
            binNext = hisPixelPkg::BinOverflow;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            binValid   <= 1'b0;
            frameDoneD <= 1'b0;
        end else begin
            binValid   <= pixelValid;
            frameDoneD <= frameDone;
        end
    end

    always_ff @(posedge clk) begin
        if (pixelValid)
            binIdx <= binNext;
    end

    binIdxInRange: assert property (@(posedge clk) disable iff (reset)
        binValid |-> (binIdx < hisPixelPkg::BinTotal));

endmodule

`default_nettype wire

// File: design/sampleCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module sampleCombiner (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  logic                       wrEn,
    input  logic [hisPixelPkg::Np-1:0] data,
    output logic                       pixelValid,
    output logic [hisPixelPkg::Np-1:0] pixelValue,
    output logic                       frameDone
);

    hisPixelPkg::combState state;

    logic [hisPixelPkg::Np-1:0] firstData; // held first sample of the pair
    logic [hisPixelPkg::Np:0]   pairSum;
    logic [hisPixelPkg::Np:0]   pairAvg;
    logic [$clog2(hisPixelPkg::PixelsPerRow)-1:0] pixelCnt;
    logic [$clog2(hisPixelPkg::RowsPerFrame)-1:0] rowCnt;
    logic lastPixel;

    assign pairSum   = {1'b0, firstData} + {1'b0, data};
    assign pairAvg   = pairSum >> $clog2(hisPixelPkg::SamplesPerPixel);
    assign lastPixel = (pixelCnt == hisPixelPkg::PixelsPerRow - 1) &&
                       (rowCnt == hisPixelPkg::RowsPerFrame - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= hisPixelPkg::firstSample;
            pixelCnt   <= '0;
            rowCnt     <= '0;
            pixelValid <= 1'b0;
            frameDone  <= 1'b0;
        end else begin
            pixelValid <= 1'b0;
            frameDone  <= 1'b0;
            if (!enable) begin
                state    <= hisPixelPkg::firstSample; // restart pairing at pixel 0
                pixelCnt <= '0;
                rowCnt   <= '0;
            end else if (wrEn) begin
                case (state)
                    hisPixelPkg::firstSample: begin
                        state <= hisPixelPkg::secondSample;
                    end
                    hisPixelPkg::secondSample: begin
                        state      <= hisPixelPkg::firstSample;
                        pixelValid <= 1'b1;
                        frameDone  <= lastPixel;
                        if (pixelCnt == hisPixelPkg::PixelsPerRow - 1) begin
                            pixelCnt <= '0;
                            if (rowCnt == hisPixelPkg::RowsPerFrame - 1)
                                rowCnt <= '0;
                            else
                                rowCnt <= rowCnt + 1'b1;
                        end else begin
                            pixelCnt <= pixelCnt + 1'b1;
                        end
                    end
                    default: state <= hisPixelPkg::firstSample;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && wrEn) begin
            if (state == hisPixelPkg::firstSample)
                firstData <= data;
            else
                pixelValue <= pairAvg[hisPixelPkg::Np-1:0];
        end
    end

    // frame end leaves the counters at pixel 0 of row 0
    frameDoneAtWrap: assert property (@(posedge clk) disable iff (reset)
        frameDone |-> (pixelValid && (pixelCnt == '0) && (rowCnt == '0)));

endmodule

`default_nettype wire

// File: design/hisRegPkg.sv
`default_nettype none

package hisRegPkg;

    localparam int AddrWidth  = 8;
    localparam int DataWidth  = 32;
    localparam int ShiftWidth = 3; // bin width is 1 << shift

    localparam logic [AddrWidth-1:0] AddrCtrl    = 8'h00;
    localparam logic [AddrWidth-1:0] AddrWinLow  = 8'h04;
    localparam logic [AddrWidth-1:0] AddrShift   = 8'h08;
    localparam logic [AddrWidth-1:0] AddrFrames  = 8'h0C;
    localparam logic [AddrWidth-1:0] AddrBinBase = 8'h10; // bin i at base + 4*i

    localparam int CtrlEnableBit = 0;
    localparam int CtrlClearBit  = 1; // self-clearing

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apbPhase;

endpackage

`default_nettype wire

// File: design/hisPixelPkg.sv
`default_nettype none

package hisPixelPkg;

    localparam int Np              = 10; // raw sample width
    localparam int PixelsPerRow    = 3;
    localparam int RowsPerFrame    = 2;
    localparam int SamplesPerPixel = 2;

    localparam int BinCount        = 8; // in-window bins
    localparam int BinTotal        = BinCount + 2; // plus underflow and overflow
    localparam int BinIdxWidth     = 4;
    localparam int CountWidth      = 16;
    localparam int FrameCountWidth = 16;

    localparam logic [BinIdxWidth-1:0] BinUnderflow = '0;
    localparam logic [BinIdxWidth-1:0] BinOverflow  = BinIdxWidth'(BinTotal - 1);

    typedef enum logic {
        firstSample,
        secondSample
    } combState;

endpackage

`default_nettype wire
